//--- surf_cout_params.svh
`ifndef SURF_COUT_PARAMS_SVH
`define SURF_COUT_PARAMS_SVH

// training word that the command lane carries during alignment
`define SURF_COUT_TRAIN 32'hA55AF00F

// training byte on the data lane; the off-phase byte is its complement
`define SURF_DOUT_TRAIN 8'hD3

// nibbles per command word, which is also the length of the phase counter
`define SURF_COUT_PHASES 8

// error counters stop here instead of wrapping
`define SURF_ERRCNT_MAX 255

`endif

//--- surf_cout_pkg.sv
`include "surf_cout_params.svh"

package surf_cout_pkg;

    // one sample of the command lane per sysclk
    typedef logic [3:0] cout_nibble_t;

    // a full command word is built from one nibble per phase
    typedef logic [`SURF_COUT_PHASES*4-1:0] cout_word_t;

    // one sample of the data lane per sysclk
    typedef logic [7:0] dout_byte_t;

    // phase counter and the offset it reloads on sync
    typedef logic [$clog2(`SURF_COUT_PHASES)-1:0] cout_phase_t;

    // wide enough to hold the saturation value
    typedef logic [$clog2(`SURF_ERRCNT_MAX+1)-1:0] err_count_t;

endpackage

//--- surf_capture_if.sv
// one aligned lane, from its aligner to the block that holds captures
interface surf_capture_if #(
    parameter type payload_t = surf_cout_pkg::cout_word_t
);

    // aligned value, only meaningful while valid is high
    payload_t data;
    // single-cycle strobe for each new aligned value
    logic     valid;
    // mismatch against the training pattern, qualified by valid
    logic     biterr;
    // pattern checking is only done while this is high
    logic     enable;

    modport src (
        output data,
        output valid,
        output biterr,
        input  enable
    );

    modport dst (
        input  data,
        input  valid,
        input  biterr,
        output enable
    );

endinterface

//--- surf_cout_parallelizer.sv
`include "surf_cout_params.svh"

// builds 32-bit command words out of the nibble stream
module surf_cout_parallelizer (
    input  logic                        sysclk_i,
    input  logic                        rst_i,
    input  logic                        sync_i,
    input  surf_cout_pkg::cout_phase_t  cout_offset_i,
    input  surf_cout_pkg::cout_nibble_t cout_i,
    surf_capture_if.src                 out
);

    localparam int WORD_W = $bits(surf_cout_pkg::cout_word_t);
    localparam int NIB_W  = $bits(surf_cout_pkg::cout_nibble_t);

    localparam surf_cout_pkg::cout_phase_t LAST_PHASE =
        surf_cout_pkg::cout_phase_t'(`SURF_COUT_PHASES - 1);

    surf_cout_pkg::cout_phase_t phase_q;
    surf_cout_pkg::cout_word_t  shift_q;
    surf_cout_pkg::cout_word_t  shift_next;
    logic                       word_done;

    // newest nibble enters at the bottom, so the oldest ends up on top
    assign shift_next = {shift_q[WORD_W-NIB_W-1:0], cout_i};

    // the word closes on the edge where the counter sits at its last phase
    assign word_done = (phase_q == LAST_PHASE);

    // software sweeps the offset to move the word boundary,
    // one nibble per step
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase_q <= '0;
        end else if (sync_i) begin
            phase_q <= cout_offset_i;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        shift_q <= shift_next;
    end

    always_ff @(posedge sysclk_i) begin
        if (word_done) begin
            out.data <= shift_next;
        end
    end

    // valid and biterr line up with the registered word
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            out.valid  <= 1'b0;
            out.biterr <= 1'b0;
        end else begin
            out.valid  <= word_done;
            out.biterr <= word_done && out.enable &&
                          (shift_next != `SURF_COUT_TRAIN);
        end
    end

endmodule

//--- surf_byte_capture.sv
`include "surf_cout_params.svh"

// takes one data byte out of every two cycles on the selected phase
module surf_byte_capture (
    input  logic                      sysclk_i,
    input  logic                      rst_i,
    input  logic                      sync_i,
    input  logic                      dout_capture_phase_i,
    input  surf_cout_pkg::dout_byte_t dout_i,
    surf_capture_if.src               out
);

    logic phase_q;
    logic take;

    // the byte is taken when the toggle agrees with the requested phase
    assign take = (phase_q == dout_capture_phase_i);

    // sync lines the toggle up with the requested phase,
    // so the first capture comes on the edge after sync
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase_q <= 1'b0;
        end else if (sync_i) begin
            phase_q <= dout_capture_phase_i;
        end else begin
            phase_q <= ~phase_q;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (take) begin
            out.data <= dout_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            out.valid  <= 1'b0;
            out.biterr <= 1'b0;
        end else begin
            out.valid  <= take;
            // on the wrong phase the training stream shows its complement
            out.biterr <= take && out.enable && (dout_i != `SURF_DOUT_TRAIN);
        end
    end

endmodule

//--- surf_capture_hold.sv
`include "surf_cout_params.svh"

// holds one aligned value per software request and counts bit errors
module surf_capture_hold #(
    parameter type payload_t = surf_cout_pkg::cout_word_t
) (
    input  logic                      sysclk_i,
    input  logic                      rst_i,
    input  logic                      enable_i,
    input  logic                      capture_req_i,
    output logic                      capture_ack_o,
    output payload_t                  data_o,
    output surf_cout_pkg::err_count_t errcnt_o,
    surf_capture_if.dst               in
);

    localparam surf_cout_pkg::err_count_t ERR_MAX =
        surf_cout_pkg::err_count_t'(`SURF_ERRCNT_MAX);

    logic grab;
    logic release_ack;

    // the aligner checks its pattern only while software enables it
    assign in.enable = enable_i;

    // a pending request is served by the next value the aligner produces
    assign grab        = capture_req_i && !capture_ack_o && in.valid;
    assign release_ack = capture_ack_o && !capture_req_i;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            capture_ack_o <= 1'b0;
        end else if (grab) begin
            capture_ack_o <= 1'b1;
        end else if (release_ack) begin
            capture_ack_o <= 1'b0;
        end
    end

    // stays put between captures, software reads it while ack is high
    always_ff @(posedge sysclk_i) begin
        if (grab) begin
            data_o <= in.data;
        end
    end

    // each completed handshake starts a fresh error window
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            errcnt_o <= '0;
        end else if (release_ack) begin
            errcnt_o <= '0;
        end else if (in.biterr && (errcnt_o != ERR_MAX)) begin
            errcnt_o <= errcnt_o + 1'b1;
        end
    end

endmodule

//--- surf_cout_interface.sv
// receive side of the training link: command and data lane alignment
module surf_cout_interface (
    input  logic                        sysclk_i,
    input  logic                        rst_i,
    input  logic                        sync_i,

    input  surf_cout_pkg::cout_nibble_t cout_i,
    // straight on to the downstream transmitter
    output surf_cout_pkg::cout_nibble_t cout_o,
    input  surf_cout_pkg::cout_phase_t  cout_offset_i,
    input  logic                        cout_enable_i,
    input  logic                        cout_capture_req_i,
    output logic                        cout_capture_ack_o,
    output logic                        cout_biterr_o,
    output surf_cout_pkg::cout_word_t   cout_data_o,
    output surf_cout_pkg::err_count_t   cout_errcnt_o,

    input  surf_cout_pkg::dout_byte_t   dout_i,
    input  logic                        dout_capture_phase_i,
    input  logic                        dout_enable_i,
    input  logic                        dout_capture_req_i,
    output logic                        dout_capture_ack_o,
    output logic                        dout_biterr_o,
    output surf_cout_pkg::dout_byte_t   dout_data_o,
    output surf_cout_pkg::err_count_t   dout_errcnt_o
);

    surf_capture_if #(.payload_t(surf_cout_pkg::cout_word_t)) cout_if ();
    surf_capture_if #(.payload_t(surf_cout_pkg::dout_byte_t)) dout_if ();

    // the nibble is forwarded untouched; only training uses the words
    assign cout_o = cout_i;

    assign cout_biterr_o = cout_if.biterr;
    assign dout_biterr_o = dout_if.biterr;

    surf_cout_parallelizer u_cout_par (
        .sysclk_i      (sysclk_i),
        .rst_i         (rst_i),
        .sync_i        (sync_i),
        .cout_offset_i (cout_offset_i),
        .cout_i        (cout_i),
        .out           (cout_if.src)
    );

    surf_capture_hold #(.payload_t(surf_cout_pkg::cout_word_t)) u_cout_hold (
        .sysclk_i      (sysclk_i),
        .rst_i         (rst_i),
        .enable_i      (cout_enable_i),
        .capture_req_i (cout_capture_req_i),
        .capture_ack_o (cout_capture_ack_o),
        .data_o        (cout_data_o),
        .errcnt_o      (cout_errcnt_o),
        .in            (cout_if.dst)
    );

    surf_byte_capture u_dout_cap (
        .sysclk_i             (sysclk_i),
        .rst_i                (rst_i),
        .sync_i               (sync_i),
        .dout_capture_phase_i (dout_capture_phase_i),
        .dout_i               (dout_i),
        .out                  (dout_if.src)
    );

    surf_capture_hold #(.payload_t(surf_cout_pkg::dout_byte_t)) u_dout_hold (
        .sysclk_i      (sysclk_i),
        .rst_i         (rst_i),
        .enable_i      (dout_enable_i),
        .capture_req_i (dout_capture_req_i),
        .capture_ack_o (dout_capture_ack_o),
        .data_o        (dout_data_o),
        .errcnt_o      (dout_errcnt_o),
        .in            (dout_if.dst)
    );

endmodule

//--- surf_cout_asserts.sv
// protocol checks for the capture handshake and the aligner strobes
module surf_cout_asserts #(
    parameter bit HOLD_SIDE = 1'b1
) (
    input logic clk_i,
    input logic rst_i,
    input logic sync_i,
    input logic req_i,
    input logic ack_i,
    input logic valid_i,
    input logic biterr_i
);

    if (HOLD_SIDE) begin : g_handshake
        ack_rise_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
            $rose(ack_i) |-> $past(req_i)) else $error("ack rose without a request");

        ack_fall_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
            $fell(ack_i) |-> !$past(req_i)) else $error("ack fell while req was high");
    end else begin : g_aligner
        // a sync that reloads the last phase may legally close two words in a row
        valid_single: assert property (@(posedge clk_i) disable iff (rst_i)
            (valid_i && !$past(sync_i)) |=> !valid_i) else $error("valid held two cycles");
    end

    biterr_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        biterr_i |-> valid_i) else $error("biterr without valid");

endmodule

bind surf_capture_hold surf_cout_asserts #(.HOLD_SIDE(1'b1)) u_hold_asserts (
    .clk_i(sysclk_i), .rst_i(rst_i), .sync_i(1'b0), .req_i(capture_req_i),
    .ack_i(capture_ack_o), .valid_i(in.valid), .biterr_i(in.biterr)
);

bind surf_cout_parallelizer surf_cout_asserts #(.HOLD_SIDE(1'b0)) u_par_asserts (
    .clk_i(sysclk_i), .rst_i(rst_i), .sync_i(sync_i), .req_i(1'b0),
    .ack_i(1'b0), .valid_i(out.valid), .biterr_i(out.biterr)
);

//--- surf_cout_tb.sv
`include "surf_cout_params.svh"

module surf_cout_tb;

    localparam int DRIVE_DLY      = 10;
    localparam int TIMEOUT_CYCLES = 6000;

    logic sysclk_i, rst_i, sync_i;
    logic cout_enable_i, cout_capture_req_i, cout_capture_ack_o, cout_biterr_o;
    logic dout_capture_phase_i, dout_enable_i, dout_capture_req_i;
    logic dout_capture_ack_o, dout_biterr_o;
    surf_cout_pkg::cout_nibble_t cout_i, cout_o;
    surf_cout_pkg::cout_phase_t  cout_offset_i;
    surf_cout_pkg::cout_word_t   cout_data_o;
    surf_cout_pkg::dout_byte_t   dout_i, dout_data_o;
    surf_cout_pkg::err_count_t   cout_errcnt_o, dout_errcnt_o;

    integer seed = 32'h1e16;
    int stream_idx = 0;
    bit stream_on = 1'b0;
    int cycles = 0;
    int errors = 0;
    int cout_biterr_seen = 0;

    surf_cout_interface DUT (.*);

    always #50 sysclk_i = ~sysclk_i;

    // stream_idx names the sample on the lanes, so at a rising edge it is the one just taken
    always @(posedge sysclk_i) begin
        #DRIVE_DLY;
        stream_idx++;
        if (stream_on) begin
            cout_i = stream_nibble(stream_idx);
            dout_i = stream_byte(stream_idx);
        end
    end

    always @(negedge sysclk_i) begin
        if (cout_biterr_o === 1'b1) begin
            cout_biterr_seen++;
        end
    end

    always @(posedge sysclk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // the training word goes out most significant nibble first
    function automatic surf_cout_pkg::cout_nibble_t stream_nibble(input int idx);
        logic [31:0] train;
        train = `SURF_COUT_TRAIN;
        return train[31 - 4 * (idx % `SURF_COUT_PHASES) -: 4];
    endfunction

    function automatic surf_cout_pkg::dout_byte_t stream_byte(input int idx);
        return (idx % 2 == 0) ? `SURF_DOUT_TRAIN : ~(`SURF_DOUT_TRAIN);
    endfunction

    function automatic surf_cout_pkg::cout_word_t expected_word(input int start);
        surf_cout_pkg::cout_word_t w;
        w = '0;
        for (int k = 0; k < `SURF_COUT_PHASES; k++) begin
            w = {w[27:0], stream_nibble(start + k)};
        end
        return w;
    endfunction

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic handshake(input bit on_dout);
        int waited;
        string lane;
        waited = 0;
        lane = on_dout ? "dout" : "cout";
        @(posedge sysclk_i);
        #DRIVE_DLY;
        dout_capture_req_i = on_dout;
        cout_capture_req_i = !on_dout;
        do begin
            @(negedge sysclk_i);
            waited++;
            if (waited > 20) begin
                $display("Error: no %s capture ack within 20 cycles of the request", lane);
                stop_run();
            end
        end while (!(on_dout ? dout_capture_ack_o : cout_capture_ack_o));
        @(posedge sysclk_i);
        #DRIVE_DLY;
        check_value({lane, "_capture_ack_o"},
                    on_dout ? dout_capture_ack_o : cout_capture_ack_o, 1);
        cout_capture_req_i = 1'b0;
        dout_capture_req_i = 1'b0;
        // ack falls and the count clears on the first edge that sees req low
        @(posedge sysclk_i);
        @(negedge sysclk_i);
        check_value({lane, "_capture_ack_o"},
                    on_dout ? dout_capture_ack_o : cout_capture_ack_o, 0);
        check_value({lane, "_errcnt_o"}, on_dout ? dout_errcnt_o : cout_errcnt_o, 0);
    endtask

    // sync lands with sample s+1, so the counter holds the offset when sample s+2 arrives
    task automatic resync(input int skew, output int word_start, output int byte_start);
        int s;
        int off;
        do begin
            @(posedge sysclk_i);
            s = stream_idx;
        end while (s % 2 != 0);
        off = (s + 2 + skew) % `SURF_COUT_PHASES;
        #DRIVE_DLY;
        sync_i = 1'b1;
        cout_offset_i = surf_cout_pkg::cout_phase_t'(off);
        dout_capture_phase_i = 1'b0;
        @(posedge sysclk_i);
        #DRIVE_DLY;
        sync_i = 1'b0;
        word_start = s + 2 + (`SURF_COUT_PHASES - off) % `SURF_COUT_PHASES;
        byte_start = s + 2;
    endtask

    task automatic test_reset_state();
        @(negedge sysclk_i);
        check_value("cout_capture_ack_o", cout_capture_ack_o, 0);
        check_value("dout_capture_ack_o", dout_capture_ack_o, 0);
        check_value("cout_biterr_o", cout_biterr_o, 0);
        check_value("dout_biterr_o", dout_biterr_o, 0);
        check_value("cout_errcnt_o", cout_errcnt_o, 0);
        check_value("dout_errcnt_o", dout_errcnt_o, 0);
        repeat (8) begin
            @(posedge sysclk_i);
            #DRIVE_DLY;
            cout_i = surf_cout_pkg::cout_nibble_t'($random(seed));
            @(negedge sysclk_i);
            check_value("cout_o", cout_o, cout_i);
        end
        stream_on = 1'b1;
    endtask

    task automatic test_aligned_capture();
        int ws, bs;
        resync(0, ws, bs);
        cout_enable_i = 1'b1;
        repeat (2 * `SURF_COUT_PHASES) @(negedge sysclk_i);
        check_value("cout_errcnt_o", cout_errcnt_o, 0);
        handshake(1'b0);
        check_value("cout_data_o", cout_data_o, `SURF_COUT_TRAIN);
    endtask

    task automatic test_misaligned_capture();
        int ws, bs, seen;
        @(posedge sysclk_i);
        #DRIVE_DLY;
        cout_enable_i = 1'b0;
        resync(1, ws, bs);
        @(negedge sysclk_i);
        check_value("cout_errcnt_o", cout_errcnt_o, 0);
        // enable covers exactly four word periods, so four words are checked
        @(posedge sysclk_i);
        #DRIVE_DLY;
        seen = cout_biterr_seen;
        cout_enable_i = 1'b1;
        repeat (4 * `SURF_COUT_PHASES) @(posedge sysclk_i);
        #DRIVE_DLY;
        cout_enable_i = 1'b0;
        repeat (3) @(negedge sysclk_i);
        check_value("cout_errcnt_o", cout_errcnt_o, 4);
        check_value("cout_biterr_o pulses", cout_biterr_seen - seen, 4);
        handshake(1'b0);
        check_value("cout_data_o", cout_data_o, expected_word(ws));
    endtask

    task automatic test_enable_gating();
        int ws, bs, seen;
        resync(3, ws, bs);
        seen = cout_biterr_seen;
        repeat (3 * `SURF_COUT_PHASES) @(negedge sysclk_i);
        check_value("cout_errcnt_o", cout_errcnt_o, 0);
        check_value("cout_biterr_o pulses", cout_biterr_seen - seen, 0);
    endtask

    task automatic test_byte_phase();
        int ws, bs;
        resync(0, ws, bs);
        dout_enable_i = 1'b1;
        repeat (4) @(negedge sysclk_i);
        check_value("dout_errcnt_o", dout_errcnt_o, 0);
        handshake(1'b1);
        check_value("dout_data_o", dout_data_o, `SURF_DOUT_TRAIN);
        // the other phase picks the odd samples of the stream
        @(posedge sysclk_i);
        #DRIVE_DLY;
        dout_capture_phase_i = 1'b1;
        repeat (8) @(negedge sysclk_i);
        check_value("dout_errcnt_o nonzero", dout_errcnt_o != 0, 1);
        handshake(1'b1);
        check_value("dout_data_o", dout_data_o, stream_byte(bs + 1));
    endtask

    task automatic test_count_clearing();
        int ws, bs;
        // both lanes are pushed off their training alignment so errors pile up
        resync(1, ws, bs);
        cout_enable_i = 1'b1;
        dout_capture_phase_i = 1'b1;
        repeat (3 * `SURF_COUT_PHASES) @(negedge sysclk_i);
        check_value("cout_errcnt_o nonzero", cout_errcnt_o != 0, 1);
        check_value("dout_errcnt_o nonzero", dout_errcnt_o != 0, 1);
        handshake(1'b0);
        handshake(1'b1);
    endtask

    initial begin
        sysclk_i = 1'b0;
        rst_i = 1'b1;
        sync_i = 1'b0;
        cout_i = '0;
        cout_offset_i = '0;
        cout_enable_i = 1'b0;
        cout_capture_req_i = 1'b0;
        dout_i = '0;
        dout_capture_phase_i = 1'b0;
        dout_enable_i = 1'b0;
        dout_capture_req_i = 1'b0;
        repeat (5) @(posedge sysclk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;
        test_reset_state();
        test_aligned_capture();
        test_misaligned_capture();
        test_enable_gating();
        test_byte_phase();
        test_count_clearing();
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

//--- surf_cout.f
+incdir+.
surf_cout_pkg.sv
surf_capture_if.sv
surf_cout_parallelizer.sv
surf_byte_capture.sv
surf_capture_hold.sv
surf_cout_interface.sv
surf_cout_asserts.sv
surf_cout_tb.sv

//--- Bender.yml
package:
  name: surf_cout

sources:
  - include_dirs:
      - .
    files:
      - surf_cout_pkg.sv
      - surf_capture_if.sv
      - surf_cout_parallelizer.sv
      - surf_byte_capture.sv
      - surf_capture_hold.sv
      - surf_cout_interface.sv
      - target: test
        files:
          - surf_cout_asserts.sv
          - surf_cout_tb.sv
